/* hdl/abr_stream_settings.svh */
//======================================================================
// Widths, depths, SRAM latency and AXI4-Lite register map macros
//======================================================================
`ifndef ABR_STREAM_SETTINGS_SVH
`define ABR_STREAM_SETTINGS_SVH

// SRAM word width, also the width written into the latency buffer
`define ABR_WR_WIDTH   128
// Width of one output sample
`define ABR_RD_WIDTH   64
// SRAM depth in words and the address and run count widths it implies
`define ABR_SRAM_WORDS 64
`define ABR_SRAM_AW    ($clog2(`ABR_SRAM_WORDS))
`define ABR_CNT_W      ($clog2(`ABR_SRAM_WORDS) + 1)
// Cycles from a read request to its data
`define ABR_SRAM_LAT   3
// Buffer size in bits, enough for one write, one read and the read latency
`define ABR_BUF_DEPTH  384

// AXI4-Lite address and data widths
`define ABR_AXIL_AW    12
`define ABR_AXIL_DW    32
// Number of 32-bit lanes in one SRAM word, as a select width
`define ABR_LANE_W     ($clog2(`ABR_WR_WIDTH / `ABR_AXIL_DW))

// Register offsets and the start of the SRAM write window
`define ABR_REG_CTRL   12'h000
`define ABR_REG_BASE   12'h004
`define ABR_REG_COUNT  12'h008
`define ABR_REG_STATUS 12'h00C
`define ABR_SRAM_WIN   12'h400

`endif

/* hdl/abr_stream_pkg.sv */
//======================================================================
// AXI4-Lite channel structs, SRAM access structs and the run setup type
//======================================================================
`include "abr_stream_settings.svh"

package abr_stream_pkg;

  // Everything the AXI4-Lite master drives
  typedef struct packed {
    logic                    awvalid;
    logic [`ABR_AXIL_AW-1:0] awaddr;
    logic                    wvalid;
    logic [`ABR_AXIL_DW-1:0] wdata;
    logic [`ABR_AXIL_DW/8-1:0] wstrb;
    logic                    bready;
    logic                    arvalid;
    logic [`ABR_AXIL_AW-1:0] araddr;
    logic                    rready;
  } abr_axil_req_t;

  // Everything the AXI4-Lite slave drives back
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    logic [1:0]              bresp;
    logic                    arready;
    logic                    rvalid;
    logic [`ABR_AXIL_DW-1:0] rdata;
    logic [1:0]              rresp;
  } abr_axil_rsp_t;

  // One 32-bit lane write into an SRAM word
  typedef struct packed {
    logic                    en;
    logic [`ABR_SRAM_AW-1:0] addr;
    logic [`ABR_LANE_W-1:0]  lane;
    logic [`ABR_AXIL_DW-1:0] data;
  } abr_sram_wr_t;

  // Full-word read request
  typedef struct packed {
    logic                    en;
    logic [`ABR_SRAM_AW-1:0] addr;
  } abr_sram_rd_t;

  // First word and number of words of a run
  typedef struct packed {
    logic [`ABR_SRAM_AW-1:0] base;
    logic [`ABR_CNT_W-1:0]   count;
  } abr_run_cfg_t;

endpackage

/* hdl/abr_stream_csr.sv */
//======================================================================
// AXI4-Lite slave with control, status and the SRAM write window
//======================================================================
`timescale 1ns/10ps
`include "abr_stream_settings.svh"

module abr_stream_csr (
  input  logic                          clk,
  input  logic                          rst_b,
  input  abr_stream_pkg::abr_axil_req_t axil_req_i,
  output abr_stream_pkg::abr_axil_rsp_t axil_rsp_o,
  input  logic                          busy_i,
  input  logic                          done_i,
  output abr_stream_pkg::abr_run_cfg_t  run_cfg_o,
  output logic                          start_o,
  output logic                          zeroize_o,
  output abr_stream_pkg::abr_sram_wr_t  sram_wr_o
);

  // The window spans the whole SRAM, so its size sets the decode boundary
  localparam int WIN_LSB = $clog2(`ABR_SRAM_WORDS * `ABR_WR_WIDTH / 8);
  localparam logic [`ABR_AXIL_AW-1:0] WIN_BASE = `ABR_SRAM_WIN;
  localparam int BYTE_LSB = $clog2(`ABR_AXIL_DW / 8);
  localparam int WORD_LSB = $clog2(`ABR_WR_WIDTH / 8);

  logic                    rsp_pending;
  logic                    wr_both;
  logic                    wr_fire;
  logic                    rd_fire;
  logic                    win_hit;
  logic                    bvalid_q;
  logic                    rvalid_q;
  logic [`ABR_AXIL_DW-1:0] rdata_d;
  logic [`ABR_AXIL_DW-1:0] rdata_q;
  logic [`ABR_SRAM_AW-1:0] base_q;
  logic [`ABR_CNT_W-1:0]   count_q;
  logic                    done_q;
  logic                    start_q;
  logic                    zeroize_q;
  logic                    wr_en_q;
  logic [`ABR_SRAM_AW-1:0] wr_addr_q;
  logic [`ABR_LANE_W-1:0]  wr_lane_q;
  logic [`ABR_AXIL_DW-1:0] wr_data_q;

  // Any outstanding B or R blocks every new request
  always_comb rsp_pending = bvalid_q | rvalid_q;
  // AW and W are only taken as a pair
  always_comb wr_both = axil_req_i.awvalid & axil_req_i.wvalid;
  always_comb wr_fire = wr_both & ~rsp_pending;
  // Writes win when a read arrives in the same cycle
  always_comb rd_fire = axil_req_i.arvalid & ~rsp_pending & ~wr_both;
  always_comb win_hit = axil_req_i.awaddr[`ABR_AXIL_AW-1:WIN_LSB] ==
                        WIN_BASE[`ABR_AXIL_AW-1:WIN_LSB];

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // Response held until the master takes it
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Register writes, CTRL pulses and SRAM lane strobes
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      base_q    <= '0;
      count_q   <= '0;
      start_q   <= 1'b0;
      zeroize_q <= 1'b0;
      wr_en_q   <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      start_q   <= 1'b0;
      zeroize_q <= 1'b0;
      // Partial window writes would corrupt a lane, so they are dropped
      wr_en_q   <= wr_fire & win_hit & (&axil_req_i.wstrb);
      if (wr_fire & axil_req_i.wstrb[0]) begin
        case (axil_req_i.awaddr)
          `ABR_REG_CTRL: begin
            start_q   <= axil_req_i.wdata[0];
            zeroize_q <= axil_req_i.wdata[1];
          end
          `ABR_REG_BASE:  base_q  <= axil_req_i.wdata[`ABR_SRAM_AW-1:0];
          `ABR_REG_COUNT: count_q <= axil_req_i.wdata[`ABR_CNT_W-1:0];
          default: ;
        endcase
      end
      // Sticky done, a new start clears it
      if (done_i) begin
        done_q <= 1'b1;
      end else if (start_q) begin
        done_q <= 1'b0;
      end
    end
  end

  // Lane write payload follows the strobe in the same cycle
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      wr_addr_q <= axil_req_i.awaddr[WORD_LSB +: `ABR_SRAM_AW];
      wr_lane_q <= axil_req_i.awaddr[BYTE_LSB +: `ABR_LANE_W];
      wr_data_q <= axil_req_i.wdata;
    end
  end

  // Read mux, window and unmapped offsets give zero
  always_comb begin
    rdata_d = '0;
    case (axil_req_i.araddr)
      `ABR_REG_BASE:   rdata_d[`ABR_SRAM_AW-1:0] = base_q;
      `ABR_REG_COUNT:  rdata_d[`ABR_CNT_W-1:0] = count_q;
      `ABR_REG_STATUS: rdata_d[1:0] = {done_q, busy_i};
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rdata_d;
    end
  end

  always_comb begin
    axil_rsp_o.awready = axil_req_i.wvalid & ~rsp_pending;
    axil_rsp_o.wready  = axil_req_i.awvalid & ~rsp_pending;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.arready = ~rsp_pending & ~wr_both;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = 2'b00;
  end

  always_comb begin
    run_cfg_o.base  = base_q;
    run_cfg_o.count = count_q;
    sram_wr_o.en    = wr_en_q;
    sram_wr_o.addr  = wr_addr_q;
    sram_wr_o.lane  = wr_lane_q;
    sram_wr_o.data  = wr_data_q;
  end
  always_comb start_o   = start_q;
  always_comb zeroize_o = zeroize_q;

endmodule

/* hdl/abr_sram_rd_seq.sv */
//======================================================================
// SRAM read sequencer with buffer credits and run tracking
//======================================================================
`timescale 1ns/10ps
`include "abr_stream_settings.svh"

module abr_sram_rd_seq (
  input  logic                         clk,
  input  logic                         rst_b,
  input  abr_stream_pkg::abr_run_cfg_t run_cfg_i,
  input  logic                         start_i,
  input  logic                         zeroize_i,
  input  logic                         out_valid_i,
  output abr_stream_pkg::abr_sram_rd_t sram_rd_o,
  output logic                         busy_o,
  output logic                         done_o
);

  // Samples produced by each SRAM word
  localparam int SPW = `ABR_WR_WIDTH / `ABR_RD_WIDTH;
  localparam int SMP_W = `ABR_CNT_W + $clog2(SPW);
  localparam int CRD_W = $clog2(`ABR_BUF_DEPTH) + 1;
  localparam logic [CRD_W-1:0] CRD_FULL = CRD_W'(`ABR_BUF_DEPTH);
  localparam logic [CRD_W-1:0] CRD_WR = CRD_W'(`ABR_WR_WIDTH);
  localparam logic [CRD_W-1:0] CRD_RD = CRD_W'(`ABR_RD_WIDTH);

  logic                    busy_q;
  logic [`ABR_SRAM_AW-1:0] addr_q;
  logic [`ABR_CNT_W-1:0]   words_q;
  logic [SMP_W-1:0]        samples_q;
  logic [CRD_W-1:0]        credit_q;
  logic [CRD_W-1:0]        credit_d;
  logic                    issue;
  logic                    start_go;

  // A read is only sent once a whole word of space is reserved
  always_comb issue = busy_q & (words_q != '0) & (credit_q >= CRD_WR) & ~zeroize_i;
  // Start while busy, or with an empty run, does nothing
  always_comb start_go = start_i & ~busy_q & (run_cfg_i.count != '0);
  // Final sample of the run
  always_comb done_o = busy_q & out_valid_i & (samples_q == SMP_W'(1));
  always_comb busy_o = busy_q & ~done_o;

  // Credit goes down by a word on issue and up by a sample on each output
  always_comb begin
    credit_d = credit_q;
    if (issue) begin
      credit_d = credit_d - CRD_WR;
    end
    if (out_valid_i) begin
      credit_d = credit_d + CRD_RD;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy_q    <= 1'b0;
      addr_q    <= '0;
      words_q   <= '0;
      samples_q <= '0;
      credit_q  <= CRD_FULL;
    end else if (zeroize_i) begin
      // Buffer is emptied at the same time, so all space comes back
      busy_q    <= 1'b0;
      addr_q    <= '0;
      words_q   <= '0;
      samples_q <= '0;
      credit_q  <= CRD_FULL;
    end else begin
      credit_q <= credit_d;
      if (start_go) begin
        busy_q    <= 1'b1;
        addr_q    <= run_cfg_i.base;
        words_q   <= run_cfg_i.count;
        samples_q <= SMP_W'(run_cfg_i.count * SPW);
      end else begin
        // Address wraps at the top of the SRAM
        if (issue) begin
          addr_q  <= addr_q + 1'b1;
          words_q <= words_q - 1'b1;
        end
        if (busy_q & out_valid_i) begin
          samples_q <= samples_q - 1'b1;
        end
        if (done_o) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    sram_rd_o.en   = issue;
    sram_rd_o.addr = addr_q;
  end

endmodule

/* hdl/abr_stream_sram.sv */
//======================================================================
// Sample SRAM with lane writes and a zeroizable read pipeline
//======================================================================
`timescale 1ns/10ps
`include "abr_stream_settings.svh"

module abr_stream_sram (
  input  logic                         clk,
  input  logic                         rst_b,
  input  logic                         zeroize_i,
  input  abr_stream_pkg::abr_sram_wr_t sram_wr_i,
  input  abr_stream_pkg::abr_sram_rd_t sram_rd_i,
  output logic                         rd_valid_o,
  output logic [`ABR_WR_WIDTH-1:0]     rd_data_o
);

  localparam int LAT = `ABR_SRAM_LAT;
  localparam int LANE = `ABR_AXIL_DW;

  logic [`ABR_WR_WIDTH-1:0] mem [`ABR_SRAM_WORDS];
  logic [LAT-1:0]           vld_q;
  logic [`ABR_WR_WIDTH-1:0] dat_q [LAT];

  // Storage is filled one 32-bit lane per write
  always_ff @(posedge clk) begin
    if (sram_wr_i.en) begin
      mem[sram_wr_i.addr][sram_wr_i.lane*LANE +: LANE] <= sram_wr_i.data;
    end
  end

  // Valid bits march with the data, zeroize drops every one in flight
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      vld_q <= '0;
    end else if (zeroize_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= sram_rd_i.en;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // Key material in flight is also wiped on zeroize
  always_ff @(posedge clk) begin
    if (zeroize_i) begin
      for (int i = 0; i < LAT; i++) begin
        dat_q[i] <= '0;
      end
    end else begin
      if (sram_rd_i.en) begin
        dat_q[0] <= mem[sram_rd_i.addr];
      end
      for (int i = 1; i < LAT; i++) begin
        dat_q[i] <= dat_q[i-1];
      end
    end
  end

  always_comb rd_valid_o = vld_q[LAT-1];
  always_comb rd_data_o  = dat_q[LAT-1];

endmodule

/* hdl/abr_rd_lat_buffer.sv */
//======================================================================
// Pre-allocated read latency buffer, wide words in, narrow samples out
//======================================================================
`timescale 1ns/10ps

module abr_rd_lat_buffer #(
  parameter int WR_WIDTH     = 128,
  parameter int RD_WIDTH     = 64,
  parameter int BUFFER_DEPTH = WR_WIDTH + RD_WIDTH
) (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize,
  input  logic                data_valid_i,
  input  logic [WR_WIDTH-1:0] data_i,
  output logic                data_valid_o,
  output logic [RD_WIDTH-1:0] data_o
);

  // One extra bit so a completely full buffer is representable
  localparam int PTR_W = $clog2(BUFFER_DEPTH) + 1;
  localparam logic [PTR_W-1:0] RD_STEP = PTR_W'(RD_WIDTH);
  localparam logic [PTR_W-1:0] WR_STEP = PTR_W'(WR_WIDTH);

  logic                    buf_rd;
  logic                    buf_wr;
  logic [BUFFER_DEPTH-1:0] buf_q;
  logic [BUFFER_DEPTH-1:0] buf_d;
  logic [BUFFER_DEPTH-1:0] buf_kept;
  logic [BUFFER_DEPTH-1:0] wr_bits;
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        wr_pos;
  logic [PTR_W-1:0]        wr_ptr_d;

  // Bit 0 of the buffer is always the oldest held bit
  // A sample leaves whenever a full sample is held
  always_comb buf_rd = wr_ptr >= RD_STEP;
  // Space was reserved upstream, so incoming words are always taken
  always_comb buf_wr = data_valid_i;

  // When a sample leaves in the same cycle the new word lands one sample lower
  always_comb begin
    wr_pos   = buf_rd ? wr_ptr - RD_STEP : wr_ptr;
    wr_ptr_d = buf_wr ? wr_pos + WR_STEP : wr_pos;
  end

  always_comb begin
    buf_kept = buf_rd ? (buf_q >> RD_WIDTH) : buf_q;
    // Bits above the fill level are zero, so OR-ing places the word
    wr_bits  = buf_wr ? (BUFFER_DEPTH'(data_i) << wr_pos) : '0;
    buf_d    = buf_kept | wr_bits;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_q  <= '0;
      wr_ptr <= '0;
    end else if (zeroize) begin
      buf_q  <= '0;
      wr_ptr <= '0;
    end else if (buf_rd | buf_wr) begin
      buf_q  <= buf_d;
      wr_ptr <= wr_ptr_d;
    end
  end

  // Nothing leaves in the zeroize cycle
  always_comb data_valid_o = buf_rd & ~zeroize;
  always_comb data_o = buf_q[RD_WIDTH-1:0];

endmodule

/* hdl/abr_stream_top.sv */
//======================================================================
// Sample streamer top level: CSR, read sequencer, SRAM and buffer
//======================================================================
`timescale 1ns/10ps
`include "abr_stream_settings.svh"

module abr_stream_top (
  input  logic                          clk,
  input  logic                          rst_b,
  input  abr_stream_pkg::abr_axil_req_t axil_req_i,
  output abr_stream_pkg::abr_axil_rsp_t axil_rsp_o,
  output logic                          sample_valid_o,
  output logic [`ABR_RD_WIDTH-1:0]      sample_o
);
  import abr_stream_pkg::*;

  abr_run_cfg_t             run_cfg;
  abr_sram_wr_t             sram_wr;
  abr_sram_rd_t             sram_rd;
  logic                     start;
  logic                     zeroize;
  logic                     busy;
  logic                     done;
  logic                     rd_valid;
  logic [`ABR_WR_WIDTH-1:0] rd_data;

  // Host side registers and SRAM fill path
  abr_stream_csr u_csr (
    .clk        (clk),
    .rst_b      (rst_b),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .busy_i     (busy),
    .done_i     (done),
    .run_cfg_o  (run_cfg),
    .start_o    (start),
    .zeroize_o  (zeroize),
    .sram_wr_o  (sram_wr)
  );

  // Credit returns come straight from the buffer output
  abr_sram_rd_seq u_seq (
    .clk         (clk),
    .rst_b       (rst_b),
    .run_cfg_i   (run_cfg),
    .start_i     (start),
    .zeroize_i   (zeroize),
    .out_valid_i (sample_valid_o),
    .sram_rd_o   (sram_rd),
    .busy_o      (busy),
    .done_o      (done)
  );

  abr_stream_sram u_sram (
    .clk        (clk),
    .rst_b      (rst_b),
    .zeroize_i  (zeroize),
    .sram_wr_i  (sram_wr),
    .sram_rd_i  (sram_rd),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data)
  );

  abr_rd_lat_buffer #(
    .WR_WIDTH     (`ABR_WR_WIDTH),
    .RD_WIDTH     (`ABR_RD_WIDTH),
    .BUFFER_DEPTH (`ABR_BUF_DEPTH)
  ) u_buf (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize      (zeroize),
    .data_valid_i (rd_valid),
    .data_i       (rd_data),
    .data_valid_o (sample_valid_o),
    .data_o       (sample_o)
  );

endmodule

/* dv/abr_stream_sva.sv */
//======================================================================
// Latency buffer occupancy and output assertions, with their bind
//======================================================================
`timescale 1ns/10ps

module abr_stream_sva #(
  parameter int WR_WIDTH     = 128,
  parameter int RD_WIDTH     = 64,
  parameter int BUFFER_DEPTH = 384,
  parameter int PTR_W        = $clog2(BUFFER_DEPTH) + 1
) (
  input logic             clk,
  input logic             rst_b,
  input logic             zeroize,
  input logic             data_valid_i,
  input logic             data_valid_o,
  input logic [PTR_W-1:0] wr_ptr
);

  int level;
  int level_after_rd;

  always_comb level = 32'(wr_ptr);
  // A sample leaves whenever one full sample is held
  always_comb level_after_rd = (level >= RD_WIDTH) ? level - RD_WIDTH : level;

  a_ptr_in_range: assert property (@(posedge clk) disable iff (!rst_b)
    level <= BUFFER_DEPTH)
    else $error("Buffer write pointer above the buffer depth");

  // Zeroize empties the buffer and the SRAM read pipeline in one cycle
  a_zeroize_clears: assert property (@(posedge clk) disable iff (!rst_b)
    zeroize |=> (!data_valid_o && !data_valid_i))
    else $error("Buffer input or output valid in the cycle after zeroize");

  // Pre-allocation upstream must leave room for every arriving word
  a_room_on_write: assert property (@(posedge clk) disable iff (!rst_b)
    data_valid_i |-> (level_after_rd + WR_WIDTH <= BUFFER_DEPTH))
    else $error("Word arrived without room in the buffer");

endmodule

bind abr_rd_lat_buffer abr_stream_sva #(
  .WR_WIDTH     (WR_WIDTH),
  .RD_WIDTH     (RD_WIDTH),
  .BUFFER_DEPTH (BUFFER_DEPTH),
  .PTR_W        (PTR_W)
) u_sva (
  .clk          (clk),
  .rst_b        (rst_b),
  .zeroize      (zeroize),
  .data_valid_i (data_valid_i),
  .data_valid_o (data_valid_o),
  .wr_ptr       (wr_ptr)
);

/* dv/abr_stream_tb.sv */
//======================================================================
// Streamer testbench: AXI4-Lite tasks, SRAM model, run table and checks
//======================================================================
`timescale 1ns/10ps
`include "abr_stream_settings.svh"

module abr_stream_tb;
  import abr_stream_pkg::*;

  localparam int NUM_RUNS = 7;
  localparam int SPW = `ABR_WR_WIDTH / `ABR_RD_WIDTH;
  localparam int LANES = `ABR_WR_WIDTH / `ABR_AXIL_DW;
  localparam int AW = `ABR_AXIL_AW;
  // Every AXI4-Lite access costs two cycles, plus margin for reset and readback
  localparam int FILL_CYCLES = `ABR_SRAM_WORDS * LANES * 3 + 100;

  // One row of the run table
  typedef struct packed {
    logic [`ABR_SRAM_AW-1:0] base;
    logic [`ABR_CNT_W-1:0]   count;
    // Number of samples to see before the zeroize write
    // A value of zero lets the run finish
    logic [7:0]              zero_after;
    logic [1:0]              status;
  } run_entry_t;

  logic                     clk;
  logic                     rst_b;
  abr_axil_req_t            axil_req;
  abr_axil_rsp_t            axil_rsp;
  logic                     sample_valid;
  logic [`ABR_RD_WIDTH-1:0] sample;
  logic [`ABR_WR_WIDTH-1:0] model [`ABR_SRAM_WORDS];
  logic [`ABR_RD_WIDTH-1:0] got_q [$];
  run_entry_t               runs [NUM_RUNS];
  int                       errors = 0;
  int                       checks = 0;
  int                       cycles = 0;
  int                       limit = 0;

  abr_stream_top u_dut (
    .clk            (clk),
    .rst_b          (rst_b),
    .axil_req_i     (axil_req),
    .axil_rsp_o     (axil_rsp),
    .sample_valid_o (sample_valid),
    .sample_o       (sample)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Samples are taken at the falling edge, where the DUT outputs are settled
  always @(negedge clk) begin
    if (rst_b && sample_valid) begin
      got_q.push_back(sample);
    end
  end

  // The limit on run length follows from the run table
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic drive_edge();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // AW and W go out together and B is taken with bready held high
  task automatic axil_write(input logic [AW-1:0] addr, input logic [31:0] data);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    do begin
      @(negedge clk);
    end while (!(axil_rsp.awready && axil_rsp.wready));
    drive_edge();
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    do begin
      @(negedge clk);
    end while (!axil_rsp.bvalid);
    // Only OKAY is ever returned
    check_val(64'(axil_rsp.bresp), 64'h0, "BRESP");
    drive_edge();
  endtask

  task automatic axil_read(input logic [AW-1:0] addr, output logic [31:0] data);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    do begin
      @(negedge clk);
    end while (!axil_rsp.arready);
    drive_edge();
    axil_req.arvalid = 1'b0;
    do begin
      @(negedge clk);
    end while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    check_val(64'(axil_rsp.rresp), 64'h0, "RRESP");
    drive_edge();
  endtask

  // Word index goes in window address bits 9:4 and the lane in bits 3:2
  function automatic logic [AW-1:0] win_addr(input int word, input int lane);
    return `ABR_SRAM_WIN | AW'(word << 4) | AW'(lane << 2);
  endfunction

  task automatic run_one(input int idx);
    run_entry_t  r;
    int          first;
    int          exp_n;
    int          err_before;
    int          seen;
    int          word;
    logic [31:0] rd;
    r = runs[idx];
    first = got_q.size();
    exp_n = int'(r.count) * SPW;
    err_before = errors;
    axil_write(`ABR_REG_BASE, 32'(r.base));
    axil_write(`ABR_REG_COUNT, 32'(r.count));
    axil_write(`ABR_REG_CTRL, 32'h1);
    // The start clears the sticky done and the run shows busy
    axil_read(`ABR_REG_STATUS, rd);
    check_val(64'(rd), 64'h1, "STATUS after start");
    if (r.zero_after != 8'd0) begin
      // Polled after the rising edge, when the monitor has stored every sample
      while (got_q.size() - first < int'(r.zero_after)) begin
        drive_edge();
      end
      axil_write(`ABR_REG_CTRL, 32'h2);
      seen = got_q.size() - first;
      // Nothing in flight may come out once zeroize has landed
      repeat (2 * `ABR_SRAM_LAT) @(posedge clk);
      #2;
      check_val(64'(got_q.size() - first), 64'(seen), "samples after zeroize");
      axil_read(`ABR_REG_STATUS, rd);
      check_val(64'(rd), 64'(r.status), "STATUS after zeroize");
    end else begin
      while (got_q.size() - first < exp_n) begin
        drive_edge();
      end
      seen = exp_n;
      axil_read(`ABR_REG_STATUS, rd);
      check_val(64'(rd), 64'(r.status), "STATUS at end of run");
      // A quiet stretch exposes any sample beyond the run length
      repeat (2 * `ABR_SRAM_LAT + 4) @(posedge clk);
      #2;
      check_val(64'(got_q.size() - first), 64'(exp_n), "sample count");
    end
    // Low half of each word first, then the high half, wrapping at the top
    for (int k = 0; k < seen; k++) begin
      word = (int'(r.base) + k / SPW) % `ABR_SRAM_WORDS;
      check_val(got_q[first + k], model[word][(k % SPW) * `ABR_RD_WIDTH +: `ABR_RD_WIDTH],
                $sformatf("run %0d sample %0d", idx, k));
    end
    $display("Run %0d base %0d count %0d: %0d samples, %0d errors", idx, r.base, r.count,
             got_q.size() - first, errors - err_before);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    int          err_before;
    axil_req = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    rst_b = 1'b0;
    void'($urandom(32'ha0bc));
    runs[0] = '{base: 6'd0, count: 7'd1, zero_after: 8'd0, status: 2'b10};
    runs[1] = '{base: 6'd7, count: 7'd5, zero_after: 8'd0, status: 2'b10};
    runs[2] = '{base: 6'd16, count: 7'd32, zero_after: 8'd0, status: 2'b10};
    // Wraps past the last word and the next run follows straight after
    runs[3] = '{base: 6'd60, count: 7'd8, zero_after: 8'd0, status: 2'b10};
    runs[4] = '{base: 6'd3, count: 7'd4, zero_after: 8'd0, status: 2'b10};
    runs[5] = '{base: 6'd10, count: 7'd20, zero_after: 8'd7, status: 2'b00};
    runs[6] = '{base: 6'd40, count: 7'd6, zero_after: 8'd0, status: 2'b10};
    limit = FILL_CYCLES;
    for (int i = 0; i < NUM_RUNS; i++) begin
      limit += 2 * int'(runs[i].count) + `ABR_SRAM_LAT + 40;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_b = 1'b1;
    drive_edge();

    err_before = errors;
    axil_read(`ABR_REG_STATUS, rd);
    check_val(64'(rd), 64'h0, "STATUS after reset");
    axil_write(`ABR_REG_BASE, 32'h15);
    axil_write(`ABR_REG_COUNT, 32'h21);
    axil_read(`ABR_REG_BASE, rd);
    check_val(64'(rd), 64'h15, "BASE readback");
    axil_read(`ABR_REG_COUNT, rd);
    check_val(64'(rd), 64'h21, "COUNT readback");
    $display("Register readback: %0d errors", errors - err_before);

    err_before = errors;
    for (int w = 0; w < `ABR_SRAM_WORDS; w++) begin
      for (int l = 0; l < LANES; l++) begin
        data = $urandom();
        model[w][l * `ABR_AXIL_DW +: `ABR_AXIL_DW] = data;
        axil_write(win_addr(w, l), data);
      end
    end
    // The window is write-only and reads back as zero
    axil_read(win_addr(1, 0), rd);
    check_val(64'(rd), 64'h0, "window read");
    axil_read(win_addr(63, 3), rd);
    check_val(64'(rd), 64'h0, "window read");
    $display("SRAM fill and window reads: %0d errors", errors - err_before);

    for (int i = 0; i < NUM_RUNS; i++) begin
      run_one(i);
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_RUNS + 2, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/abr_stream_pkg.sv
hdl/abr_stream_csr.sv
hdl/abr_sram_rd_seq.sv
hdl/abr_stream_sram.sv
hdl/abr_rd_lat_buffer.sv
hdl/abr_stream_top.sv
dv/abr_stream_sva.sv
dv/abr_stream_tb.sv

/* Makefile */
# Verilator build and run for the sample streamer testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= abr_stream_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: compile run clean

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides the result, a missing pass line counts as a failure too
run: compile
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
